//--- build.f
+incdir+logic
+incdir+tb
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/operand_forward.sv
logic/execute_unit.sv
logic/pipeline_control.sv
logic/int_pipeline.sv
tb/tb_int_pipeline.sv

//--- run.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and scan the log for a failure
set -o pipefail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_int_pipeline -Mdir obj_dir -o tb_int_pipeline &&
./obj_dir/tb_int_pipeline 2>&1 | tee sim.log &&
! grep -q "TEST RESULT: FAIL" sim.log &&
grep -q "TEST RESULT: PASS" sim.log ||
{ echo "Simulation did not pass, see sim.log"; exit 1; }

//--- tb/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// R-type function codes in the mix, fixed shifts first
localparam logic [5:0] R_FUNCTS [18] = '{
    isa_pkg::FN_SLL, isa_pkg::FN_SRL, isa_pkg::FN_SRA, isa_pkg::FN_SLLV,
    isa_pkg::FN_SRLV, isa_pkg::FN_SRAV, isa_pkg::FN_MOVZ, isa_pkg::FN_MOVN,
    isa_pkg::FN_ADD, isa_pkg::FN_ADDU, isa_pkg::FN_SUB, isa_pkg::FN_SUBU,
    isa_pkg::FN_AND, isa_pkg::FN_OR, isa_pkg::FN_XOR, isa_pkg::FN_NOR,
    isa_pkg::FN_SLT, isa_pkg::FN_SLTU
};

// I-type opcodes, LUI last
localparam logic [5:0] I_OPS [6] = '{
    isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU, isa_pkg::OP_ANDI,
    isa_pkg::OP_ORI, isa_pkg::OP_XORI, isa_pkg::OP_LUI
};

// Architectural registers as software sees them
pipe_pkg::word_t ref_regs [`CORE_REG_COUNT];
logic [31:0]     lcg_state;

function automatic void model_reset();
    foreach (ref_regs[i]) begin
        ref_regs[i] = '0;
    end
    lcg_state = 32'd50;
endfunction

// LCG step
function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Small pool r0..r5, so hazards are common
function automatic pipe_pkg::reg_addr_t pick_reg();
    logic [31:0] r;
    r = next_rand();
    return pipe_pkg::reg_addr_t'(r[26:24] % 3'd6);
endfunction

function automatic pipe_pkg::word_t random_instr();
    logic [31:0]         r;
    logic [31:0]         imm_r;
    int                  kind;
    pipe_pkg::reg_addr_t rs;
    pipe_pkg::reg_addr_t rt;
    pipe_pkg::reg_addr_t rd;
    r     = next_rand();
    imm_r = next_rand();
    rs    = pick_reg();
    rt    = pick_reg();
    rd    = pick_reg();
    kind  = int'(r[29:24]) % 24;
    if (kind >= 18) begin
        // LUI leaves rs zero
        if (kind == 23) begin
            rs = '0;
        end
        return {I_OPS[kind - 18], rs, rt, imm_r[31:16]};
    end
    // shamt field only meaningful for fixed shifts
    return {6'h00, rs, rt, rd, (kind < 3) ? imm_r[20:16] : 5'd0, R_FUNCTS[kind]};
endfunction

// One instruction on ref_regs, returns the expected result record
function automatic pipe_pkg::result_t run_model(input pipe_pkg::word_t w);
    pipe_pkg::result_t res;
    pipe_pkg::word_t   a;
    pipe_pkg::word_t   b;
    pipe_pkg::word_t   sext;
    pipe_pkg::word_t   zext;
    logic [32:0]       wide;
    a           = ref_regs[w[25:21]];
    b           = ref_regs[w[20:16]];
    sext        = {{16{w[15]}}, w[15:0]};
    zext        = {16'h0000, w[15:0]};
    res.rd_addr = (w[31:26] == 6'h00) ? w[15:11] : w[20:16];
    res.data    = '0;
    res.write   = 1'b1;
    wide        = '0;
    case (w[31:26])
        6'h00: begin
            case (w[5:0])
                isa_pkg::FN_SLL:  res.data = b << w[10:6];
                isa_pkg::FN_SRL:  res.data = b >> w[10:6];
                isa_pkg::FN_SRA:  res.data = $signed(b) >>> w[10:6];
                isa_pkg::FN_SLLV: res.data = b << a[4:0];
                isa_pkg::FN_SRLV: res.data = b >> a[4:0];
                isa_pkg::FN_SRAV: res.data = $signed(b) >>> a[4:0];
                isa_pkg::FN_MOVZ: begin
                    res.data  = a;
                    res.write = (b == 0);
                end
                isa_pkg::FN_MOVN: begin
                    res.data  = a;
                    res.write = (b != 0);
                end
                // 33-bit signed sum, overflow when the top two bits differ
                isa_pkg::FN_ADD: begin
                    wide      = {a[31], a} + {b[31], b};
                    res.data  = wide[31:0];
                    res.write = (wide[32] == wide[31]);
                end
                isa_pkg::FN_ADDU: res.data = a + b;
                isa_pkg::FN_SUB: begin
                    wide      = {a[31], a} - {b[31], b};
                    res.data  = wide[31:0];
                    res.write = (wide[32] == wide[31]);
                end
                isa_pkg::FN_SUBU: res.data = a - b;
                isa_pkg::FN_AND:  res.data = a & b;
                isa_pkg::FN_OR:   res.data = a | b;
                isa_pkg::FN_XOR:  res.data = a ^ b;
                isa_pkg::FN_NOR:  res.data = ~(a | b);
                isa_pkg::FN_SLT:  res.data = {31'd0, $signed(a) < $signed(b)};
                isa_pkg::FN_SLTU: res.data = {31'd0, a < b};
                default:          res.write = 1'b0;
            endcase
        end
        isa_pkg::OP_ADDI: begin
            wide      = {a[31], a} + {sext[31], sext};
            res.data  = wide[31:0];
            res.write = (wide[32] == wide[31]);
        end
        isa_pkg::OP_ADDIU: res.data = a + sext;
        isa_pkg::OP_ANDI:  res.data = a & zext;
        isa_pkg::OP_ORI:   res.data = a | zext;
        isa_pkg::OP_XORI:  res.data = a ^ zext;
        isa_pkg::OP_LUI:   res.data = {w[15:0], 16'h0000};
        default:           res.write = 1'b0;
    endcase
    // r0 hardwired to zero
    if (res.write && res.rd_addr != '0) begin
        ref_regs[res.rd_addr] = res.data;
    end
    return res;
endfunction

`endif

//--- tb/tb_int_pipeline.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_int_pipeline;

    // Full-rate phase followed by a random back-pressure phase
    localparam int STEADY_COUNT = 300;
    localparam int RANDOM_COUNT = 3000;
    localparam int CLK_PERIOD   = 20;

    logic              clk;
    logic              rst_n;
    pipe_pkg::word_t   instr;
    logic              instr_valid;
    logic              instr_ready;
    pipe_pkg::result_t result;
    logic              result_valid;
    logic              result_ready;

    // Expected records with acceptance cycle or -1 for unchecked latency
    pipe_pkg::result_t exp_q [$];
    int                accept_q [$];
    int                cycle;
    logic              steady;
    logic              random_ready;
    logic              held_prev;
    pipe_pkg::result_t result_prev;

    `include "tb_ref_model.svh"

    int_pipeline i_int_pipeline (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_result(input string name, input pipe_pkg::result_t got,
                                input pipe_pkg::result_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t: %s got rd=%0d data=%h write=%b, %s",
                $time, name, got.rd_addr, got.data, got.write,
                $sformatf("expected rd=%0d data=%h write=%b",
                    exp.rd_addr, exp.data, exp.write)));
        end
    endtask

    task automatic match_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic verify_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("Error at %0t: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    ////////////////////
    // Drivers
    ////////////////////

    // One clock with inputs changed 1 ns after the edge
    task automatic drive_cycle(input logic valid, input pipe_pkg::word_t w,
                               output logic taken);
        logic [31:0] r;
        instr       = w;
        instr_valid = valid;
        if (random_ready) begin
            r = next_rand();
            // Ready about three cycles in four
            result_ready = (r[28:27] != 2'b00);
        end
        @(posedge clk);
        taken = valid && instr_ready;
        #1;
    endtask

    // Word held until accepted
    task automatic send_instr(input pipe_pkg::word_t w);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            drive_cycle(1'b1, w, taken);
        end
    endtask

    task automatic drain();
        logic taken;
        while (exp_q.size() != 0) begin
            drive_cycle(1'b0, '0, taken);
        end
    endtask

    ////////////////////
    // Monitor
    ////////////////////

    always @(posedge clk) begin
        int accept_at;
        if (rst_n) begin
            cycle = cycle + 1;
            match_flag("instr_ready", instr_ready, !result_valid || result_ready);
            // Refused result still offered unchanged
            if (held_prev) begin
                match_flag("result_valid", result_valid, 1'b1);
                check_result("result", result, result_prev);
            end
            if (result_valid && result_ready) begin
                if (exp_q.size() == 0) begin
                    fail_run("Result transferred with no instruction outstanding");
                end else begin
                    check_result("result", result, exp_q.pop_front());
                    accept_at = accept_q.pop_front();
                    if (accept_at >= 0) begin
                        verify_count("latency", cycle - accept_at, 3);
                    end
                end
            end
            if (instr_valid && instr_ready) begin
                exp_q.push_back(run_model(instr));
                accept_q.push_back(steady ? cycle : -1);
            end
            held_prev   = result_valid && !result_ready;
            result_prev = result;
        end
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        logic        taken;
        logic [31:0] gap;
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr        = '0;
        instr_valid  = 1'b0;
        result_ready = 1'b0;
        steady       = 1'b0;
        random_ready = 1'b0;
        held_prev    = 1'b0;
        result_prev  = '0;
        cycle        = 0;
        taken        = 1'b0;
        gap          = '0;
        model_reset();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Empty pipe ready even with result_ready low
        match_flag("result_valid", result_valid, 1'b0);
        match_flag("instr_ready", instr_ready, 1'b1);
        // Back-to-back with no stalls
        steady       = 1'b1;
        result_ready = 1'b1;
        repeat (STEADY_COUNT) begin
            send_instr(random_instr());
        end
        drain();
        steady       = 1'b0;
        // Random stalls and input gaps
        random_ready = 1'b1;
        repeat (RANDOM_COUNT) begin
            gap = next_rand();
            if (gap[30:29] == 2'b00) begin
                drive_cycle(1'b0, '0, taken);
            end
            send_instr(random_instr());
        end
        drain();
        random_ready = 1'b0;
        result_ready = 1'b1;
        // Quiet tail must carry no stray results
        repeat (5) begin
            drive_cycle(1'b0, '0, taken);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // 40 cycles per instruction
    initial begin
        repeat ((STEADY_COUNT + RANDOM_COUNT) * 40) @(posedge clk);
        fail_run("Watchdog expired before all results were received");
    end

endmodule

//--- logic/int_pipeline.sv
`timescale 1ns/1ps

module int_pipeline (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::word_t   instr,
    input  logic              instr_valid,
    output logic              instr_ready,
    output pipe_pkg::result_t result,
    output logic              result_valid,
    input  logic              result_ready
);

    logic                advance;
    logic                ex_valid;
    logic                rf_wr_en;
    pipe_pkg::word_t     dec_instr;
    pipe_pkg::ctrl_t     dec_ctrl;
    pipe_pkg::reg_addr_t dec_rs_addr;
    pipe_pkg::reg_addr_t dec_rt_addr;
    pipe_pkg::reg_addr_t dec_rd_addr;
    pipe_pkg::word_t     dec_imm_ext;
    pipe_pkg::word_t     rs_data;
    pipe_pkg::word_t     rt_data;
    pipe_pkg::ex_stage_t ex_q;
    pipe_pkg::word_t     fwd_a;
    pipe_pkg::word_t     fwd_b;
    pipe_pkg::result_t   ex_result;

    pipeline_control i_pipeline_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .advance      (advance),
        .ex_valid     (ex_valid)
    );

    ////////////////////
    // Decode stage
    ////////////////////

    instr_decoder i_instr_decoder (
        .instr   (dec_instr),
        .ctrl    (dec_ctrl),
        .rs_addr (dec_rs_addr),
        .rt_addr (dec_rt_addr),
        .rd_addr (dec_rd_addr),
        .imm_ext (dec_imm_ext)
    );

    // Retiring result writes back as it leaves
    assign rf_wr_en = result_valid && result_ready && result.write;

    reg_file i_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (dec_rs_addr),
        .rt_addr (dec_rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (rf_wr_en),
        .wr_addr (result.rd_addr),
        .wr_data (result.data)
    );

    ////////////////////
    // Execute stage
    ////////////////////

    operand_forward i_operand_forward (
        .ex         (ex_q),
        .held       (result),
        .held_valid (result_valid),
        .op_a       (fwd_a),
        .op_b       (fwd_b)
    );

    execute_unit i_execute_unit (
        .ctrl    (ex_q.ctrl),
        .op_a    (fwd_a),
        .op_b    (fwd_b),
        .imm_ext (ex_q.imm_ext),
        .rd_addr (ex_q.rd_addr),
        .result  (ex_result)
    );

    // Stage payloads, bubbles carry don't-care data
    always_ff @(posedge clk) begin
        if (advance) begin
            dec_instr <= instr;
            ex_q      <= '{ctrl: dec_ctrl, rs_addr: dec_rs_addr, rt_addr: dec_rt_addr,
                           rd_addr: dec_rd_addr, op_a: rs_data, op_b: rt_data,
                           imm_ext: dec_imm_ext};
        end
        // Result slot only reloads behind a real instruction
        if (advance && ex_valid) begin
            result <= ex_result;
        end
    end

    // Refused result is presented unchanged
    a_result_stable: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && !result_ready |=> $stable(result))
        else $error("FAIL: result changed while stalled");

endmodule

//--- logic/pipeline_control.sv
`timescale 1ns/1ps

module pipeline_control (
    input  logic clk,
    input  logic rst_n,
    input  logic instr_valid,
    output logic instr_ready,
    output logic result_valid,
    input  logic result_ready,
    output logic advance,
    output logic ex_valid
);

    // Decode slot occupied
    logic dec_valid;

    // Whole pipe moves unless a held result is refused
    assign advance     = !result_valid || result_ready;
    assign instr_ready = advance;

    // Valid bits shift one stage per advance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid    <= 1'b0;
            ex_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else if (advance) begin
            dec_valid    <= instr_valid;
            ex_valid     <= dec_valid;
            result_valid <= ex_valid;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Back-pressure freezes every stage
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && !result_ready |=> result_valid && $stable(ex_valid) && $stable(dec_valid))
        else $error("FAIL: pipeline moved while the result was stalled");

    // Upstream keeps an offered instruction until it is taken
    a_instr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid && !instr_ready |=> instr_valid)
        else $error("FAIL: instruction withdrawn before it was accepted");

endmodule

//--- logic/execute_unit.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module execute_unit (
    input  pipe_pkg::ctrl_t     ctrl,
    input  pipe_pkg::word_t     op_a,
    input  pipe_pkg::word_t     op_b,
    input  pipe_pkg::word_t     imm_ext,
    input  pipe_pkg::reg_addr_t rd_addr,
    output pipe_pkg::result_t   result
);

    localparam int MSB = `CORE_DATA_W - 1;

    pipe_pkg::word_t          alu_b;
    pipe_pkg::word_t          sum;
    pipe_pkg::word_t          diff;
    pipe_pkg::word_t          alu_out;
    pipe_pkg::word_t          shift_out;
    logic [`CORE_SHAMT_W-1:0] shamt;
    logic                     overflow;
    logic                     move_ok;

    ////////////////////
    // Operand selection
    ////////////////////

    // Immediate replaces rt for I-type
    assign alu_b = ctrl.use_imm ? imm_ext : op_b;
    // Variable shifts take the low bits of rs
    assign shamt = ctrl.shamt_from_reg ? op_a[`CORE_SHAMT_W-1:0] : ctrl.shamt;

    ////////////////////
    // ALU
    ////////////////////

    assign sum  = op_a + alu_b;
    assign diff = op_a - alu_b;

    always_comb begin
        alu_out  = sum;
        overflow = 1'b0;
        case (ctrl.alu_op)
            isa_pkg::ALU_ADD: begin
                // Same signs in, different sign out
                overflow = (op_a[MSB] == alu_b[MSB]) && (sum[MSB] != op_a[MSB]);
            end
            isa_pkg::ALU_ADDU: alu_out = sum;
            isa_pkg::ALU_SUB: begin
                alu_out  = diff;
                overflow = (op_a[MSB] != alu_b[MSB]) && (diff[MSB] != op_a[MSB]);
            end
            isa_pkg::ALU_SUBU: alu_out = diff;
            isa_pkg::ALU_AND:  alu_out = op_a & alu_b;
            isa_pkg::ALU_OR:   alu_out = op_a | alu_b;
            isa_pkg::ALU_XOR:  alu_out = op_a ^ alu_b;
            isa_pkg::ALU_NOR:  alu_out = ~(op_a | alu_b);
            isa_pkg::ALU_SLT: begin
                alu_out    = '0;
                alu_out[0] = $signed(op_a) < $signed(alu_b);
            end
            isa_pkg::ALU_SLTU: begin
                alu_out    = '0;
                alu_out[0] = op_a < alu_b;
            end
            // Immediate into the upper half
            isa_pkg::ALU_LUI: alu_out = {alu_b[15:0], 16'h0000};
            default: ;
        endcase
    end

    ////////////////////
    // Barrel shifter
    ////////////////////

    // Shifts always act on rt
    always_comb begin
        case (ctrl.shift_op)
            isa_pkg::SH_SRL: shift_out = op_b >> shamt;
            isa_pkg::SH_SRA: shift_out = $signed(op_b) >>> shamt;
            default:         shift_out = op_b << shamt;
        endcase
    end

    ////////////////////
    // Result and write qualification
    ////////////////////

    // MOVZ on rt zero, MOVN on rt non-zero
    assign move_ok = ctrl.movz ? (op_b == '0) :
                     ctrl.movn ? (op_b != '0) : 1'b1;

    always_comb begin
        result.rd_addr = rd_addr;
        case (ctrl.res_sel)
            isa_pkg::RES_SHIFT: result.data = shift_out;
            isa_pkg::RES_MOVE:  result.data = op_a;
            default:            result.data = alu_out;
        endcase
        result.write = ctrl.reg_w && move_ok && !(ctrl.of_w_disable && overflow);
    end

endmodule

//--- logic/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
    input  pipe_pkg::ex_stage_t ex,
    input  pipe_pkg::result_t   held,
    input  logic                held_valid,
    output pipe_pkg::word_t     op_a,
    output pipe_pkg::word_t     op_b
);

    // Held result is the instruction just ahead of execute
    logic held_live;
    logic fwd_a;
    logic fwd_b;

    // Overflowed or failed moves carry write low and are skipped
    assign held_live = held_valid && held.write && (held.rd_addr != '0);

    assign fwd_a = held_live && (held.rd_addr == ex.rs_addr);
    assign fwd_b = held_live && (held.rd_addr == ex.rt_addr);

    // rs side
    assign op_a = fwd_a ? held.data : ex.op_a;
    // rt side
    assign op_b = fwd_b ? held.data : ex.op_b;

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  pipe_pkg::reg_addr_t rs_addr,
    input  pipe_pkg::reg_addr_t rt_addr,
    output pipe_pkg::word_t     rs_data,
    output pipe_pkg::word_t     rt_data,
    input  logic                wr_en,
    input  pipe_pkg::reg_addr_t wr_addr,
    input  pipe_pkg::word_t     wr_data
);

    pipe_pkg::word_t regs [`CORE_REG_COUNT];

    // Architectural state starts cleared, r0 never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Reads see a same-cycle write
    assign rs_data = (rs_addr == '0) ? '0 :
                     (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 :
                     (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

    // r0 stays zero across every write
    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
        else $error("FAIL: register 0 holds a non-zero value");

endmodule

//--- logic/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  pipe_pkg::word_t     instr,
    output pipe_pkg::ctrl_t     ctrl,
    output pipe_pkg::reg_addr_t rs_addr,
    output pipe_pkg::reg_addr_t rt_addr,
    output pipe_pkg::reg_addr_t rd_addr,
    output pipe_pkg::word_t     imm_ext
);

    isa_pkg::opcode_e opcode;
    isa_pkg::funct_e  funct;
    // R-type writes rd and I-type writes rt
    logic             r_type;
    logic             sign_imm;

    assign opcode = isa_pkg::opcode_e'(instr[31:26]);
    assign funct  = isa_pkg::funct_e'(instr[5:0]);

    always_comb begin
        // Unknown encodings fall out as a non-writing ADDU
        ctrl.alu_op         = isa_pkg::ALU_ADDU;
        ctrl.shift_op       = isa_pkg::SH_SLL;
        ctrl.res_sel        = isa_pkg::RES_ALU;
        ctrl.use_imm        = 1'b0;
        ctrl.shamt_from_reg = 1'b0;
        ctrl.shamt          = instr[10:6];
        ctrl.reg_w          = 1'b0;
        ctrl.of_w_disable   = 1'b0;
        ctrl.movz           = 1'b0;
        ctrl.movn           = 1'b0;
        r_type              = 1'b0;
        sign_imm            = 1'b0;
        case (opcode)
            isa_pkg::OP_SPECIAL: begin
                r_type     = 1'b1;
                ctrl.reg_w = 1'b1;
                case (funct)
                    isa_pkg::FN_ADD: begin
                        ctrl.alu_op       = isa_pkg::ALU_ADD;
                        ctrl.of_w_disable = 1'b1;
                    end
                    isa_pkg::FN_ADDU: ctrl.alu_op = isa_pkg::ALU_ADDU;
                    isa_pkg::FN_SUB: begin
                        ctrl.alu_op       = isa_pkg::ALU_SUB;
                        ctrl.of_w_disable = 1'b1;
                    end
                    isa_pkg::FN_SUBU: ctrl.alu_op = isa_pkg::ALU_SUBU;
                    isa_pkg::FN_AND:  ctrl.alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:   ctrl.alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_XOR:  ctrl.alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::FN_NOR:  ctrl.alu_op = isa_pkg::ALU_NOR;
                    isa_pkg::FN_SLT:  ctrl.alu_op = isa_pkg::ALU_SLT;
                    isa_pkg::FN_SLTU: ctrl.alu_op = isa_pkg::ALU_SLTU;
                    // Fixed shifts take the amount from bits 10:6
                    isa_pkg::FN_SLL, isa_pkg::FN_SRL, isa_pkg::FN_SRA: begin
                        ctrl.res_sel  = isa_pkg::RES_SHIFT;
                        ctrl.shift_op = isa_pkg::shift_op_e'(
                            funct[1:0] - 2'd1 + {1'b0, ~|funct[1:0]});
                    end
                    // Variable shifts take the amount from rs
                    isa_pkg::FN_SLLV, isa_pkg::FN_SRLV, isa_pkg::FN_SRAV: begin
                        ctrl.res_sel        = isa_pkg::RES_SHIFT;
                        ctrl.shamt_from_reg = 1'b1;
                        ctrl.shift_op       = isa_pkg::shift_op_e'(
                            funct[1:0] - 2'd1 + {1'b0, ~|funct[1:0]});
                    end
                    isa_pkg::FN_MOVZ: begin
                        ctrl.res_sel = isa_pkg::RES_MOVE;
                        ctrl.movz    = 1'b1;
                    end
                    isa_pkg::FN_MOVN: begin
                        ctrl.res_sel = isa_pkg::RES_MOVE;
                        ctrl.movn    = 1'b1;
                    end
                    default: ctrl.reg_w = 1'b0;
                endcase
            end
            isa_pkg::OP_ADDI: begin
                ctrl.alu_op       = isa_pkg::ALU_ADD;
                ctrl.of_w_disable = 1'b1;
                sign_imm          = 1'b1;
            end
            isa_pkg::OP_ADDIU: begin
                ctrl.alu_op = isa_pkg::ALU_ADDU;
                sign_imm    = 1'b1;
            end
            isa_pkg::OP_ANDI: ctrl.alu_op = isa_pkg::ALU_AND;
            isa_pkg::OP_ORI:  ctrl.alu_op = isa_pkg::ALU_OR;
            isa_pkg::OP_XORI: ctrl.alu_op = isa_pkg::ALU_XOR;
            isa_pkg::OP_LUI:  ctrl.alu_op = isa_pkg::ALU_LUI;
            default: ;
        endcase
        // Every kept I-type uses the immediate and writes rt
        if (opcode inside {isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU, isa_pkg::OP_ANDI,
                isa_pkg::OP_ORI, isa_pkg::OP_XORI, isa_pkg::OP_LUI}) begin
            ctrl.use_imm = 1'b1;
            ctrl.reg_w   = 1'b1;
        end
    end

    // Register fields
    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];
    assign rd_addr = r_type ? instr[15:11] : instr[20:16];

    // Sign extension only for the add immediates
    assign imm_ext = {{16{sign_imm & instr[15]}}, instr[15:0]};

endmodule

//--- logic/pipe_pkg.sv
`include "core_macros.svh"

package pipe_pkg;

    typedef logic [`CORE_DATA_W-1:0] word_t;
    typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t;

    // Decoded control for one instruction
    typedef struct packed {
        isa_pkg::alu_op_e         alu_op;
        isa_pkg::shift_op_e       shift_op;
        isa_pkg::res_sel_e        res_sel;
        // Second ALU operand from immediate
        logic                     use_imm;
        // Variable shift, amount from rs
        logic                     shamt_from_reg;
        logic [`CORE_SHAMT_W-1:0] shamt;
        logic                     reg_w;
        // Drop the write on signed overflow
        logic                     of_w_disable;
        logic                     movz;
        logic                     movn;
    } ctrl_t;

    // Execute stage payload
    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rs_addr;
        reg_addr_t rt_addr;
        reg_addr_t rd_addr;
        // Register file values, before forwarding
        word_t     op_a;
        word_t     op_b;
        word_t     imm_ext;
    } ex_stage_t;

    // Architectural effect of one instruction
    typedef struct packed {
        reg_addr_t rd_addr;
        word_t     data;
        logic      write;
    } result_t;

endpackage

//--- logic/isa_pkg.sv
package isa_pkg;

    // Major opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // SPECIAL function codes, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_MOVZ = 6'h0a,
        FN_MOVN = 6'h0b,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    // ALU operation
    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU, ALU_LUI
    } alu_op_e;

    // Barrel shifter kind
    typedef enum logic [1:0] {SH_SLL, SH_SRL, SH_SRA} shift_op_e;

    // Which unit drives the result word
    typedef enum logic [1:0] {RES_ALU, RES_SHIFT, RES_MOVE} res_sel_e;

endpackage

//--- logic/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath sizing for the integer pipeline

// Data word and instruction word width
`define CORE_DATA_W 32

// Register address width
`define CORE_REG_ADDR_W 5

// General registers, r0 included
`define CORE_REG_COUNT 32

// Shift amount field and variable shift width
`define CORE_SHAMT_W 5

`endif
